// File: rtl/lcd_geom_pkg.sv
package lcd_geom_pkg;

  // Panel and character grid
  localparam int SCREEN_W = 320;
  localparam int SCREEN_H = 240;
  localparam int CELL_PX  = 8;    // Square cells, one glyph byte per row

  localparam int TEXT_COLS  = SCREEN_W / CELL_PX;     // 40
  localparam int TEXT_ROWS  = SCREEN_H / CELL_PX;     // 30
  localparam int TEXT_CELLS = TEXT_COLS * TEXT_ROWS;  // 1200
  localparam int FONT_BYTES = 1024;                   // 128 glyphs x 8 rows

  localparam logic [7:0] CMD_RAMWR = 8'h2C;  // Memory write command

  typedef logic [15:0] rgb565_t;
  typedef logic [10:0] text_addr_t;
  typedef logic [9:0]  font_addr_t;  // {code[6:0], glyph row}

  // Colours after reset
  localparam rgb565_t FG0_RESET = 16'hFD20;  // Orange
  localparam rgb565_t BG0_RESET = 16'h000F;  // Navy
  localparam rgb565_t FG1_RESET = 16'h07FF;  // Cyan
  localparam rgb565_t BG1_RESET = 16'h000F;  // Navy

  typedef struct packed {
    logic       is_cmd;  // Command byte, coordinates unused
    logic [8:0] x;       // 0..319, outer loop
    logic [7:0] y;       // 0..239, inner loop
  } scan_tok_t;

  typedef struct packed {
    scan_tok_t  scan;
    logic [7:0] code;   // Bit 7 selects colour set 1
  } char_tok_t;

  typedef struct packed {
    char_tok_t  ch;
    logic [7:0] glyph;  // Glyph row, MSB is the leftmost pixel
  } glyph_tok_t;

  typedef struct packed {
    rgb565_t fg0;
    rgb565_t bg0;
    rgb565_t fg1;
    rgb565_t bg1;
  } palette_t;

endpackage

// File: rtl/host_regs_pkg.sv
package host_regs_pkg;

  localparam int HOST_IDX_W = 11;  // Wide enough for the text buffer

  // Host write targets
  typedef enum logic [2:0] {
    SEL_TEXT,  // Text buffer byte
    SEL_FONT,  // Font byte
    SEL_FG0,
    SEL_BG0,
    SEL_FG1,
    SEL_BG1
  } reg_sel_e;

  typedef struct packed {
    logic                  valid;
    reg_sel_e              sel;
    logic [HOST_IDX_W-1:0] index;  // Text or font index
    logic [15:0]           data;   // Memories take the low byte
  } host_wr_t;

  // Byte write into one of the stage memories
  typedef struct packed {
    logic                  valid;
    logic [HOST_IDX_W-1:0] addr;
    logic [7:0]            data;
  } mem_wr_t;

endpackage

// File: rtl/host_reg_file.sv
`timescale 1ns/1ps

module host_reg_file import lcd_geom_pkg::*, host_regs_pkg::*; (
  input  logic     clk,
  input  logic     reset_button,
  input  host_wr_t host_wr,
  output mem_wr_t  text_wr,  // To the text buffer in char_fetch
  output mem_wr_t  font_wr,  // To the font memory in glyph_fetch
  output palette_t palette
);

  palette_t palette_q;

  // Memory strobes, written at the same edge as the colour registers
  always_comb begin
    text_wr.valid = host_wr.valid && (host_wr.sel == SEL_TEXT);
    text_wr.addr  = host_wr.index;
    text_wr.data  = host_wr.data[7:0];

    font_wr.valid = host_wr.valid && (host_wr.sel == SEL_FONT);
    font_wr.addr  = host_wr.index;  // Font index in the low 10 bits
    font_wr.data  = host_wr.data[7:0];
  end

  always_ff @(posedge clk) begin
    if (reset_button) begin
      palette_q.fg0 <= FG0_RESET;
      palette_q.bg0 <= BG0_RESET;
      palette_q.fg1 <= FG1_RESET;
      palette_q.bg1 <= BG1_RESET;
    end else if (host_wr.valid) begin
      case (host_wr.sel)
        SEL_FG0: palette_q.fg0 <= host_wr.data;
        SEL_BG0: palette_q.bg0 <= host_wr.data;
        SEL_FG1: palette_q.fg1 <= host_wr.data;
        SEL_BG1: palette_q.bg1 <= host_wr.data;
        default: ;  // Memory writes go out on the strobes
      endcase
    end
  end

  assign palette = palette_q;

endmodule

// File: rtl/frame_scanner.sv
`timescale 1ns/1ps

module frame_scanner import lcd_geom_pkg::*; (
  input  logic      clk,
  input  logic      reset_button,
  input  logic      lcd_fmark,
  output scan_tok_t tok,
  output logic      tok_valid,
  input  logic      tok_ready,
  output logic      frame_busy
);

  typedef enum logic [1:0] {
    ST_IDLE,  // Waiting for a frame mark
    ST_CMD,   // Offering the command token
    ST_SCAN   // Walking the pixels
  } state_e;

  state_e     state;
  logic       fmark_s1;
  logic       fmark_s2;
  logic [8:0] x_cnt;
  logic [7:0] y_cnt;
  logic       last_x;
  logic       last_y;

  // Two flop synchroniser for the panel frame mark
  always_ff @(posedge clk) begin
    if (reset_button) begin
      fmark_s1 <= 1'b0;
      fmark_s2 <= 1'b0;
    end else begin
      fmark_s1 <= lcd_fmark;
      fmark_s2 <= fmark_s1;
    end
  end

  assign last_x = (x_cnt == 9'(SCREEN_W - 1));
  assign last_y = (y_cnt == 8'(SCREEN_H - 1));

  // Counters only move when the token is taken
  always_ff @(posedge clk) begin
    if (reset_button) begin
      state <= ST_IDLE;
      x_cnt <= '0;
      y_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (fmark_s2) begin  // Marks ignored outside idle
          state <= ST_CMD;
          x_cnt <= '0;
          y_cnt <= '0;
        end
        ST_CMD: if (tok_ready) state <= ST_SCAN;
        ST_SCAN: if (tok_ready) begin
          if (last_y) begin
            y_cnt <= '0;
            if (last_x) state <= ST_IDLE;  // Pixel (319, 239) gone
            else        x_cnt <= x_cnt + 9'd1;
          end else begin
            y_cnt <= y_cnt + 8'd1;  // y is the inner loop
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign tok_valid  = (state != ST_IDLE);
  assign frame_busy = (state != ST_IDLE);
  assign tok        = '{is_cmd: (state == ST_CMD), x: x_cnt, y: y_cnt};

endmodule

// File: rtl/char_fetch.sv
`timescale 1ns/1ps

module char_fetch import lcd_geom_pkg::*, host_regs_pkg::*; (
  input  logic      clk,
  input  logic      reset_button,
  input  mem_wr_t   text_wr,
  input  scan_tok_t in_tok,
  input  logic      in_valid,
  output logic      in_ready,
  output char_tok_t out_tok,
  output logic      out_valid,
  input  logic      out_ready
);

  logic [7:0] text_ram [TEXT_CELLS];  // One code per cell, row major
  text_addr_t rd_addr;
  logic       take;
  scan_tok_t  tok_q;
  logic [7:0] code_q;

  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;

  // Cell index x/8 + 40 * y/8
  assign rd_addr = text_addr_t'(in_tok.x / CELL_PX)
                 + text_addr_t'(in_tok.y / CELL_PX) * text_addr_t'(TEXT_COLS);

  always_ff @(posedge clk) begin
    if (text_wr.valid && (text_wr.addr < text_addr_t'(TEXT_CELLS)))
      text_ram[text_wr.addr] <= text_wr.data;  // Out of range index dropped
  end

  // Token and code load together, both held under stall
  always_ff @(posedge clk) begin
    if (take) begin
      tok_q  <= in_tok;
      code_q <= in_tok.is_cmd ? 8'h00 : text_ram[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_button)
      out_valid <= 1'b0;
    else if (in_ready)
      out_valid <= in_valid;
  end

  assign out_tok = '{scan: tok_q, code: code_q};

endmodule

// File: rtl/glyph_fetch.sv
`timescale 1ns/1ps

module glyph_fetch import lcd_geom_pkg::*, host_regs_pkg::*; (
  input  logic       clk,
  input  logic       reset_button,
  input  mem_wr_t    font_wr,
  input  char_tok_t  in_tok,
  input  logic       in_valid,
  output logic       in_ready,
  output glyph_tok_t out_tok,
  output logic       out_valid,
  input  logic       out_ready
);

  logic [7:0] font_ram [FONT_BYTES];  // 8 bytes per glyph, top row first
  font_addr_t rd_addr;
  logic       take;
  char_tok_t  tok_q;
  logic [7:0] glyph_q;

  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;

  // Code bit 7 is the colour set, not part of the glyph index
  assign rd_addr = {in_tok.code[6:0], in_tok.scan.y[2:0]};

  always_ff @(posedge clk) begin
    if (font_wr.valid && (font_wr.addr < 11'(FONT_BYTES)))
      font_ram[font_addr_t'(font_wr.addr)] <= font_wr.data;
  end

  always_ff @(posedge clk) begin
    if (take) begin
      tok_q   <= in_tok;
      glyph_q <= in_tok.scan.is_cmd ? 8'h00 : font_ram[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_button)
      out_valid <= 1'b0;
    else if (in_ready)
      out_valid <= in_valid;  // Empty slot or downstream took ours
  end

  assign out_tok = '{ch: tok_q, glyph: glyph_q};

endmodule

// File: rtl/pixel_serializer.sv
`timescale 1ns/1ps

module pixel_serializer import lcd_geom_pkg::*; (
  input  logic       clk,
  input  logic       reset_button,
  input  palette_t   palette,
  input  glyph_tok_t in_tok,
  input  logic       in_valid,
  output logic       in_ready,
  output logic [7:0] lcd_d,
  output logic       lcd_rs,     // Low for command, high for data
  output logic       lcd_valid,
  input  logic       lcd_ready
);

  logic    busy_q;     // A token is being sent
  logic    phase_q;    // 0 high byte, 1 low byte
  logic    cmd_q;
  rgb565_t pix_q;
  logic    glyph_bit;
  logic    set1;
  rgb565_t pix_next;
  logic    last_byte;
  logic    take;

  // Leftmost pixel sits in glyph bit 7
  assign glyph_bit = in_tok.glyph[3'd7 - in_tok.ch.scan.x[2:0]];
  assign set1      = in_tok.ch.code[7];

  always_comb begin
    case ({set1, glyph_bit})
      2'b00:   pix_next = palette.bg0;
      2'b01:   pix_next = palette.fg0;
      2'b10:   pix_next = palette.bg1;
      default: pix_next = palette.fg1;
    endcase
  end

  assign last_byte = cmd_q || phase_q;  // Command is a single byte
  assign in_ready  = !busy_q || (lcd_ready && last_byte);
  assign take      = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset_button) begin
      busy_q  <= 1'b0;
      phase_q <= 1'b0;
    end else if (take) begin
      busy_q  <= 1'b1;
      phase_q <= 1'b0;
    end else if (busy_q && lcd_ready) begin
      if (last_byte) busy_q  <= 1'b0;
      else           phase_q <= 1'b1;
    end
  end

  // Colour sampled once per pixel
  always_ff @(posedge clk) begin
    if (take) begin
      cmd_q <= in_tok.ch.scan.is_cmd;
      pix_q <= pix_next;
    end
  end

  assign lcd_valid = busy_q;
  assign lcd_rs    = !cmd_q;
  assign lcd_d     = cmd_q ? CMD_RAMWR : (phase_q ? pix_q[7:0] : pix_q[15:8]);

endmodule

// File: rtl/text_lcd_top.sv
`timescale 1ns/1ps

module text_lcd_top import lcd_geom_pkg::*, host_regs_pkg::*; (
  input  logic       clk,
  input  logic       reset_button,
  input  logic       lcd_fmark,    // Async frame mark from the panel
  input  host_wr_t   host_wr,
  input  logic       lcd_ready,
  output logic [7:0] lcd_d,
  output logic       lcd_rs,
  output logic       lcd_valid,
  output logic       frame_busy
);

  mem_wr_t    text_wr;
  mem_wr_t    font_wr;
  palette_t   palette;

  // Stage links
  scan_tok_t  scan_tok;
  logic       scan_valid;
  logic       scan_ready;
  char_tok_t  char_tok;
  logic       char_valid;
  logic       char_ready;
  glyph_tok_t glyph_tok;
  logic       glyph_valid;
  logic       glyph_ready;

  host_reg_file regs0 (
    .clk(clk), .reset_button(reset_button), .host_wr(host_wr),
    .text_wr(text_wr), .font_wr(font_wr), .palette(palette)
  );

  frame_scanner scan0 (
    .clk(clk), .reset_button(reset_button), .lcd_fmark(lcd_fmark),
    .tok(scan_tok), .tok_valid(scan_valid), .tok_ready(scan_ready),
    .frame_busy(frame_busy)
  );

  char_fetch chr0 (
    .clk(clk), .reset_button(reset_button), .text_wr(text_wr),
    .in_tok(scan_tok), .in_valid(scan_valid), .in_ready(scan_ready),
    .out_tok(char_tok), .out_valid(char_valid), .out_ready(char_ready)
  );

  glyph_fetch gly0 (
    .clk(clk), .reset_button(reset_button), .font_wr(font_wr),
    .in_tok(char_tok), .in_valid(char_valid), .in_ready(char_ready),
    .out_tok(glyph_tok), .out_valid(glyph_valid), .out_ready(glyph_ready)
  );

  pixel_serializer ser0 (
    .clk(clk), .reset_button(reset_button), .palette(palette),
    .in_tok(glyph_tok), .in_valid(glyph_valid), .in_ready(glyph_ready),
    .lcd_d(lcd_d), .lcd_rs(lcd_rs), .lcd_valid(lcd_valid), .lcd_ready(lcd_ready)
  );

endmodule

// File: tb/tb_text_lcd.sv
`timescale 1ns/1ps

module tb_text_lcd import lcd_geom_pkg::*, host_regs_pkg::*; ();

  localparam int FRAME_BYTES = 1 + 2 * SCREEN_W * SCREEN_H;  // Command plus two per pixel

  logic       clk;
  logic       reset_button;
  logic       lcd_fmark;
  host_wr_t   host_wr;
  logic       lcd_ready;
  logic [7:0] lcd_d;
  logic       lcd_rs;
  logic       lcd_valid;
  logic       frame_busy;

  int          errors;
  int          checks;
  int          i;
  logic [31:0] lfsr;
  logic [31:0] r;
  logic [7:0]  text_mem [TEXT_CELLS];  // Model of the text buffer
  logic [7:0]  font_mem [FONT_BYTES];  // Model of the font memory
  palette_t    m_pal;                  // Model of the colour registers

  text_lcd_top dut0 (
    .clk(clk), .reset_button(reset_button), .lcd_fmark(lcd_fmark), .host_wr(host_wr),
    .lcd_ready(lcd_ready), .lcd_d(lcd_d), .lcd_rs(lcd_rs), .lcd_valid(lcd_valid),
    .frame_busy(frame_busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    int          k;
    val = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Colour of one screen pixel from the text, font and palette models
  function automatic rgb565_t pixel_color(input int x, input int y);
    text_addr_t ta;
    font_addr_t fa;
    logic [7:0] code;
    logic [7:0] glyph;
    logic [2:0] col;
    logic       on;
    ta    = text_addr_t'((x / CELL_PX) + TEXT_COLS * (y / CELL_PX));
    code  = text_mem[ta];
    fa    = {code[6:0], 3'(y % CELL_PX)};  // Bit 7 is the colour set only
    glyph = font_mem[fa];
    col   = 3'(x % CELL_PX);
    on    = glyph[3'd7 - col];             // Leftmost pixel in bit 7
    if (code[7]) return on ? m_pal.fg1 : m_pal.bg1;
    return on ? m_pal.fg0 : m_pal.bg0;
  endfunction

  // {rs, byte} for stream position n
  function automatic logic [8:0] expected_byte(input int n);
    int      p;
    rgb565_t c;
    if (n == 0) return {1'b0, 8'h2C};  // Memory write command
    p = (n - 1) / 2;
    c = pixel_color(p / SCREEN_H, p % SCREEN_H);  // x outer and y inner
    return ((n - 1) % 2 == 0) ? {1'b1, c[15:8]} : {1'b1, c[7:0]};
  endfunction

  task automatic host_write(input reg_sel_e sel, input logic [10:0] index,
                            input logic [15:0] data);
    @(negedge clk);
    host_wr.valid = 1'b1;
    host_wr.sel   = sel;
    host_wr.index = index;
    host_wr.data  = data;
  endtask

  task automatic host_release();
    @(negedge clk);
    host_wr.valid = 1'b0;
  endtask

  // Start mark, stream check against the model and idle tail of one frame
  task automatic receive_frame(input bit mid_marks);
    int         cyc;
    int         nbytes;
    logic       v;
    logic [7:0] d;
    logic       rs;
    logic [8:0] want;
    logic       hold;
    logic [7:0] hold_d;
    logic       hold_rs;
    cyc    = 0;
    nbytes = 0;
    hold   = 1'b0;
    hold_d = '0;
    hold_rs = 1'b0;
    @(negedge clk);
    lcd_fmark = 1'b1;
    repeat (2) @(negedge clk);
    lcd_fmark = 1'b0;
    while (!lcd_valid && cyc < 200) begin  // Start latency varies
      @(negedge clk);
      cyc++;
    end
    if (!lcd_valid) begin
      errors++;
      $display("No LCD byte appeared within 200 cycles of the frame mark");
      return;
    end
    checks++;
    if (!frame_busy) begin
      errors++;
      $display("[FAIL] frame_busy 0x%h at first byte, expected 0x1", frame_busy);
    end
    cyc = 0;
    while (nbytes < FRAME_BYTES && cyc < 1_500_000) begin
      v  = lcd_valid;  // Registered outputs hold until the next rising edge
      d  = lcd_d;
      rs = lcd_rs;
      if (hold) begin  // Stalled byte must not move
        checks++;
        if (!v || d !== hold_d || rs !== hold_rs) begin
          errors++;
          $display("[FAIL] stall: lcd_valid 0x%h lcd_d 0x%h->0x%h lcd_rs 0x%h->0x%h",
                   v, hold_d, d, hold_rs, rs);
        end
      end
      lcd_fmark = mid_marks && ((nbytes >= 1000 && nbytes < 1004) ||
                                (nbytes >= 90000 && nbytes < 90004));
      lcd_ready = (rand_bits(1) != 0);
      hold      = v && !lcd_ready;
      hold_d    = d;
      hold_rs   = rs;
      if (v && lcd_ready) begin  // Transfer at the coming rising edge
        want = expected_byte(nbytes);
        checks++;
        if ({rs, d} !== want) begin
          errors++;
          $display("[FAIL] byte %0d: lcd_rs 0x%h lcd_d 0x%h, expected lcd_rs 0x%h lcd_d 0x%h",
                   nbytes, rs, d, want[8], want[7:0]);
        end
        nbytes++;
      end
      @(negedge clk);
      cyc++;
    end
    lcd_fmark = 1'b0;
    lcd_ready = 1'b0;
    if (nbytes < FRAME_BYTES) begin
      errors++;
      $display("Frame stalled after %0d of %0d bytes", nbytes, FRAME_BYTES);
      return;
    end
    cyc = 0;
    while (frame_busy && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    repeat (30) begin  // No extra bytes and no restart from the mid-frame marks
      checks++;
      if (lcd_valid || frame_busy) begin
        errors++;
        $display("[FAIL] after frame: lcd_valid 0x%h frame_busy 0x%h, expected 0x0",
                 lcd_valid, frame_busy);
      end
      @(negedge clk);
    end
  endtask

  initial begin
    lfsr         = 32'hc5a5_dd69;
    errors       = 0;
    checks       = 0;
    reset_button = 1'b1;
    lcd_fmark    = 1'b0;
    lcd_ready    = 1'b0;
    host_wr      = '0;
    m_pal.fg0    = 16'hFD20;  // Colours after reset
    m_pal.bg0    = 16'h000F;
    m_pal.fg1    = 16'h07FF;
    m_pal.bg1    = 16'h000F;
    repeat (8) @(negedge clk);
    reset_button = 1'b0;

    repeat (50) begin  // Quiet without a frame mark
      @(negedge clk);
      checks++;
      if (lcd_valid || frame_busy) begin
        errors++;
        $display("[FAIL] idle: lcd_valid 0x%h frame_busy 0x%h, expected 0x0",
                 lcd_valid, frame_busy);
      end
    end

    for (i = 0; i < TEXT_CELLS; i++) begin
      r = rand_bits(8);
      text_mem[text_addr_t'(i)] = r[7:0];
      host_write(SEL_TEXT, 11'(i), {8'h00, r[7:0]});
    end
    for (i = 0; i < FONT_BYTES; i++) begin
      r = rand_bits(8);
      font_mem[font_addr_t'(i)] = r[7:0];
      host_write(SEL_FONT, 11'(i), {8'h00, r[7:0]});
    end
    host_release();
    receive_frame(1'b0);  // Reset colours

    r = rand_bits(16);
    m_pal.fg0 = r[15:0];
    host_write(SEL_FG0, '0, m_pal.fg0);
    r = rand_bits(16);
    m_pal.bg0 = r[15:0];
    host_write(SEL_BG0, '0, m_pal.bg0);
    r = rand_bits(16);
    m_pal.fg1 = r[15:0];
    host_write(SEL_FG1, '0, m_pal.fg1);
    r = rand_bits(16);
    m_pal.bg1 = r[15:0];
    host_write(SEL_BG1, '0, m_pal.bg1);
    host_release();
    receive_frame(1'b1);  // New colours with marks pulsed mid-frame

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: filelist.f
rtl/lcd_geom_pkg.sv
rtl/host_regs_pkg.sv
rtl/host_reg_file.sv
rtl/frame_scanner.sv
rtl/char_fetch.sv
rtl/glyph_fetch.sv
rtl/pixel_serializer.sv
rtl/text_lcd_top.sv
tb/tb_text_lcd.sv

// File: Makefile
TOP = tb_text_lcd
RTL = rtl/lcd_geom_pkg.sv rtl/host_regs_pkg.sv rtl/host_reg_file.sv rtl/frame_scanner.sv \
      rtl/char_fetch.sv rtl/glyph_fetch.sv rtl/pixel_serializer.sv rtl/text_lcd_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module text_lcd_top $(RTL)

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
